// ==== Bender.yml ====
package:
  name: branch_predict

sources:
  - ras_pkg.sv
  - fetch_decode.sv
  - return_stack.sv
  - predict_out.sv
  - branch_predict_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_branch_predict.sv

// ==== branch_predict_top.sv ====
`timescale 1ns/1ps

module branch_predict_top #(
	parameter int ENTRIES = 4
) (
	input  logic                 CLK,
	input  logic                 nRST,
	input  ras_pkg::fetch_t      fetch,
	output ras_pkg::prediction_t pred
);

	ras_pkg::decoded_t dec;
	logic [31:0]       top_addr;
	logic              top_valid;

	// decode register, one cycle after fetch
	fetch_decode i_fetch_decode (
		.CLK   (CLK),
		.nRST  (nRST),
		.fetch (fetch),
		.dec   (dec)
	);

	return_stack #(
		.ENTRIES (ENTRIES)
	) i_return_stack (
		.CLK       (CLK),
		.nRST      (nRST),
		.dec       (dec),
		.top_addr  (top_addr),
		.top_valid (top_valid)
	);

	// top is read before this item's own stack update
	predict_out i_predict_out (
		.CLK       (CLK),
		.nRST      (nRST),
		.dec       (dec),
		.top_addr  (top_addr),
		.top_valid (top_valid),
		.pred      (pred)
	);

endmodule

// ==== fetch_decode.sv ====
`timescale 1ns/1ps

module fetch_decode (
	input  logic              CLK,
	input  logic              nRST,
	input  ras_pkg::fetch_t   fetch,
	output ras_pkg::decoded_t dec
);

	logic               valid_q;
	logic [31:0]        pc_q;
	ras_pkg::rv_instr_u instr_q;

	logic        jal_hit;
	logic        jalr_hit;
	logic        jal_rd_link;
	logic        jalr_rd_link;
	logic        jalr_rs1_link;
	logic        same_link;
	logic [31:0] j_imm;

	// x1 and x5 are the only registers hinted as link
	function automatic logic is_link(input logic [4:0] r);
		return (r == ras_pkg::LINK_X1) || (r == ras_pkg::LINK_X5);
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= fetch.valid;
		end
	end

	// payload only loaded with a valid item
	always_ff @(posedge CLK) begin
		if (fetch.valid) begin
			pc_q    <= fetch.pc;
			instr_q <= fetch.instr;
		end
	end

	assign jal_hit       = instr_q.j_fmt.opcode == ras_pkg::OPC_JAL;
	assign jalr_hit      = instr_q.i_fmt.opcode == ras_pkg::OPC_JALR;
	assign jal_rd_link   = is_link(instr_q.j_fmt.rd);
	assign jalr_rd_link  = is_link(instr_q.i_fmt.rd);
	assign jalr_rs1_link = is_link(instr_q.i_fmt.rs1);
	assign same_link     = instr_q.i_fmt.rd == instr_q.i_fmt.rs1;

	// unscramble imm[20|10:1|11|19:12], bit 0 is always zero
	assign j_imm = {{11{instr_q.j_fmt.imm[19]}},
		instr_q.j_fmt.imm[19],
		instr_q.j_fmt.imm[7:0],
		instr_q.j_fmt.imm[8],
		instr_q.j_fmt.imm[18:9],
		1'b0};

	always_comb begin
		dec.valid      = valid_q;
		dec.is_jal     = 1'b0;
		dec.op         = ras_pkg::RAS_NONE;
		dec.link_addr  = pc_q + 32'd4;
		dec.jal_target = pc_q + j_imm;
		if (valid_q) begin
			if (jal_hit) begin
				dec.is_jal = 1'b1;
				if (jal_rd_link) begin
					dec.op = ras_pkg::RAS_PUSH; // call
				end
			end else if (jalr_hit) begin
				case ({jalr_rd_link, jalr_rs1_link})
					2'b01:   dec.op = ras_pkg::RAS_POP; // return
					2'b10:   dec.op = ras_pkg::RAS_PUSH;
					2'b11:   dec.op = same_link ? ras_pkg::RAS_PUSH : ras_pkg::RAS_POP_PUSH;
					default: dec.op = ras_pkg::RAS_NONE;
				endcase
			end
		end
	end

endmodule

// ==== predict_out.sv ====
`timescale 1ns/1ps

module predict_out (
	input  logic                 CLK,
	input  logic                 nRST,
	input  ras_pkg::decoded_t    dec,
	input  logic [31:0]          top_addr,
	input  logic                 top_valid,
	output ras_pkg::prediction_t pred
);

	logic        pops;
	logic        taken;
	logic [31:0] target;

	logic        valid_q;
	logic        taken_q;
	logic [31:0] target_q;
	logic [31:0] pc_q;

	assign pops = (dec.op == ras_pkg::RAS_POP) || (dec.op == ras_pkg::RAS_POP_PUSH);

	always_comb begin
		taken  = 1'b0;
		target = '0;
		if (dec.is_jal) begin
			taken  = 1'b1;
			target = dec.jal_target;
		end else if (pops && top_valid) begin
			taken  = 1'b1;
			target = top_addr; // return to last pushed link address
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
			taken_q <= 1'b0;
		end else begin
			valid_q <= dec.valid;
			taken_q <= taken;
		end
	end

	always_ff @(posedge CLK) begin
		if (dec.valid) begin
			target_q <= target;
			pc_q     <= dec.link_addr - 32'd4; // back out the pc
		end
	end

	always_comb begin
		pred.valid  = valid_q;
		pred.taken  = taken_q;
		pred.target = target_q;
		pred.pc     = pc_q;
	end

	assert property (@(posedge CLK) disable iff (!nRST)
		pred.taken |-> pred.valid);

endmodule

// ==== ras_pkg.sv ====
package ras_pkg;

	// rv32i major opcodes for the two unconditional jumps
	localparam logic [6:0] OPC_JAL  = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;

	localparam logic [4:0] LINK_X1 = 5'd1; // ra
	localparam logic [4:0] LINK_X5 = 5'd5; // t0, alternate link register

	// one fetched word, seen as J-type for jal or as I-type for jalr
	typedef union packed {
		struct packed {
			logic [19:0] imm;    // imm[20|10:1|11|19:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} j_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
	} rv_instr_u;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		rv_instr_u   instr;
	} fetch_t;

	typedef enum logic [1:0] {
		RAS_NONE     = 2'b00,
		RAS_PUSH     = 2'b01,
		RAS_POP      = 2'b10,
		RAS_POP_PUSH = 2'b11
	} ras_op_e;

	typedef struct packed {
		logic        valid;
		logic        is_jal;
		ras_op_e     op;
		logic [31:0] link_addr;  // pc + 4
		logic [31:0] jal_target; // pc + J immediate
	} decoded_t;

	typedef struct packed {
		logic        valid;
		logic        taken;
		logic [31:0] target;
		logic [31:0] pc;
	} prediction_t;

endpackage

// ==== return_stack.sv ====
`timescale 1ns/1ps

module return_stack #(
	parameter int ENTRIES = 4
) (
	input  logic              CLK,
	input  logic              nRST,
	input  ras_pkg::decoded_t dec,
	output logic [31:0]       top_addr,
	output logic              top_valid
);

	localparam int PTR_W = $clog2(ENTRIES);
	localparam int CNT_W = PTR_W + 1;

	logic [31:0]      stack [ENTRIES];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] nxt_ptr;
	logic [PTR_W-1:0] top_idx;
	logic [PTR_W-1:0] wr_idx;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] nxt_count;
	logic             wr_en;
	logic             full;
	logic             empty;

	assign top_idx   = ptr - 1'b1; // natural wrap, depth is a power of two
	assign full      = count == CNT_W'(ENTRIES);
	assign empty     = count == '0;
	assign top_addr  = stack[top_idx];
	assign top_valid = !empty;

	always_comb begin
		nxt_ptr   = ptr;
		nxt_count = count;
		wr_en     = 1'b0;
		wr_idx    = ptr;
		if (dec.valid) begin
			case (dec.op)
				ras_pkg::RAS_PUSH: begin
					wr_en     = 1'b1;
					nxt_ptr   = ptr + 1'b1;
					nxt_count = full ? count : count + 1'b1; // oldest entry lost on overflow
				end
				ras_pkg::RAS_POP: begin
					if (!empty) begin
						nxt_ptr   = top_idx;
						nxt_count = count - 1'b1;
					end
				end
				ras_pkg::RAS_POP_PUSH: begin
					wr_en = 1'b1;
					if (!empty) begin
						wr_idx = top_idx; // swap top in place
					end else begin
						nxt_ptr   = ptr + 1'b1;
						nxt_count = count + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr   <= '0;
			count <= '0;
		end else begin
			ptr   <= nxt_ptr;
			count <= nxt_count;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			stack[wr_idx] <= dec.link_addr;
		end
	end

	assert property (@(posedge CLK) disable iff (!nRST)
		count <= CNT_W'(ENTRIES));

	// underflowing return must not disturb the pointer
	assert property (@(posedge CLK) disable iff (!nRST)
		(dec.valid && dec.op == ras_pkg::RAS_POP && empty) |=> ptr == $past(ptr));

endmodule

// ==== tb_branch_predict.sv ====
`timescale 1ns/1ps

module tb_branch_predict;

	localparam int ENTRIES = 4;

	logic                 CLK;
	logic                 nRST;
	ras_pkg::fetch_t      fetch;
	ras_pkg::prediction_t pred;

	logic [31:0]          lfsr = 32'h940b2be5;
	logic [31:0]          m_stack [$];     // oldest at the front
	ras_pkg::prediction_t exp_pipe [$];
	string                name_pipe [$];
	ras_pkg::prediction_t exp_now = '0;
	string                exp_name = "reset";
	string                cur_test = "reset";
	int                   n_checked = 0;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) i_clock_gen (.CLK(CLK), .nRST(nRST));

	branch_predict_top #(.ENTRIES(ENTRIES)) i_dut (
		.CLK   (CLK),
		.nRST  (nRST),
		.fetch (fetch),
		.pred  (pred)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic next_lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], next_lfsr_bit()};
		return v;
	endfunction

	function automatic logic link_reg(input logic [4:0] r);
		return r == 5'd1 || r == 5'd5;
	endfunction

	function automatic logic [4:0] rand_link();
		return next_lfsr_bit() ? 5'd5 : 5'd1;
	endfunction

	function automatic logic [4:0] rand_nonlink();
		logic [4:0] r;
		r = rand_bits(5);
		if (link_reg(r)) r = r ^ 5'b10000; // x17 or x21
		return r;
	endfunction

	function automatic logic [31:0] rand_pc();
		return {rand_bits(30), 2'b00};
	endfunction

	// even byte offset, sign-extended from bit 20
	function automatic logic [31:0] rand_off();
		logic [20:0] o;
		o = {rand_bits(20), 1'b0};
		return {{11{o[20]}}, o};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, ras_pkg::OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {rand_bits(12), rs1, 3'b000, rd, ras_pkg::OPC_JALR};
	endfunction

	function automatic logic [31:0] enc_filler();
		logic [6:0] opc;
		opc = rand_bits(7);
		if (opc == ras_pkg::OPC_JAL || opc == ras_pkg::OPC_JALR) opc = opc ^ 7'h10;
		return {rand_bits(25), opc};
	endfunction

	// reference: predict from the current stack, then pop and/or push
	function automatic ras_pkg::prediction_t model_step(input logic [31:0] pc,
			input logic [31:0] instr, input logic [31:0] off);
		ras_pkg::prediction_t p;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic       jal;
		logic       call;
		logic       ret;
		rd   = instr[11:7];
		rs1  = instr[19:15];
		jal  = instr[6:0] == ras_pkg::OPC_JAL;
		call = 1'b0;
		ret  = 1'b0;
		if (jal) begin
			call = link_reg(rd);
		end else if (instr[6:0] == ras_pkg::OPC_JALR) begin
			call = link_reg(rd);
			ret  = link_reg(rs1) && !(link_reg(rd) && rd == rs1);
		end
		p = '{valid: 1'b1, taken: 1'b0, target: 32'd0, pc: pc};
		if (jal) begin
			p.taken  = 1'b1;
			p.target = pc + off;
		end else if (ret && m_stack.size() > 0) begin
			p.taken  = 1'b1;
			p.target = m_stack[$];
		end
		if (ret && m_stack.size() > 0) void'(m_stack.pop_back());
		if (call) begin
			m_stack.push_back(pc + 32'd4);
			if (m_stack.size() > ENTRIES) void'(m_stack.pop_front()); // overflow drops oldest
		end
		return p;
	endfunction

	// one entry per falling edge, checked two edges later
	task automatic advance_pipe(input ras_pkg::prediction_t p);
		exp_pipe.push_back(p);
		name_pipe.push_back(cur_test);
		if (exp_pipe.size() > 2) begin
			exp_now  = exp_pipe.pop_front();
			exp_name = name_pipe.pop_front();
		end
	endtask

	task automatic send_item(input logic [31:0] pc, input logic [31:0] instr,
			input logic [31:0] off);
		@(negedge CLK);
		fetch.valid = 1'b1;
		fetch.pc    = pc;
		fetch.instr = instr;
		advance_pipe(model_step(pc, instr, off));
	endtask

	task automatic send_idle();
		@(negedge CLK);
		fetch.valid = 1'b0;
		advance_pipe('0);
	endtask

	task automatic send_call();
		logic [31:0] off;
		off = rand_off();
		if (next_lfsr_bit()) send_item(rand_pc(), enc_jal(rand_link(), off), off);
		else send_item(rand_pc(), enc_jalr(rand_link(), rand_nonlink()), '0);
	endtask

	task automatic send_return();
		send_item(rand_pc(), enc_jalr(5'd0, rand_link()), '0);
	endtask

	task automatic drain_stack();
		for (int i = 0; i < ENTRIES && m_stack.size() > 0; i++) send_return();
	endtask

	function automatic logic pipe_busy();
		foreach (exp_pipe[i]) if (exp_pipe[i].valid) return 1'b1;
		return 1'b0;
	endfunction

	assert property (@(posedge CLK) disable iff (!nRST)
		exp_now.valid ? (pred === exp_now) : (pred.valid === 1'b0))
		begin
			if (exp_now.valid) n_checked++;
		end
	else begin
		$display("MISMATCH test=%s expected=%h actual=%h", exp_name, exp_now, $sampled(pred));
		$display(">>> FAIL");
		$fatal(1, "prediction differs from reference");
	end

	// mid-cycle, away from the register edge
	assert property (@(negedge CLK) !nRST |-> !pred.valid)
	else begin
		$display("pred.valid was high while reset was asserted");
		$display(">>> FAIL");
		$fatal(1, "valid during reset");
	end

	initial begin
		int          n;
		logic [31:0] off;
		logic [4:0]  r;
		fetch = '0;

		// reset: bubbles keep the expected pipe in step
		n = 0;
		while (nRST !== 1'b1 && n < 20) begin
			send_idle();
			n++;
		end
		if (nRST !== 1'b1) begin
			$display("reset was never released");
			$display(">>> FAIL");
			$fatal(1, "reset timeout");
		end
		send_idle();
		send_return(); // empty stack, not taken

		cur_test = "direct_jumps";
		for (int i = 0; i < 8; i++) begin
			off = rand_off();
			if (i[0]) off = off | 32'hfff00000; // force backward jump
			send_item(rand_pc(), enc_jal(rand_link(), off), off);
			off = rand_off();
			send_item(rand_pc(), enc_jal(rand_nonlink(), off), off);
			send_item(rand_pc(), enc_filler(), '0);
			send_item(rand_pc(), enc_jalr(rand_nonlink(), rand_nonlink()), '0);
		end

		cur_test = "nested";
		drain_stack();
		for (int i = 0; i < 40; i++) begin
			if (m_stack.size() == 0) send_call();
			else if (m_stack.size() == ENTRIES) send_return();
			else if (next_lfsr_bit()) send_call();
			else send_return();
		end

		cur_test = "overflow";
		drain_stack();
		for (int i = 0; i < 6; i++) begin
			off = rand_off();
			send_item(rand_pc(), enc_jal(5'd1, off), off);
		end
		repeat (6) send_return();

		cur_test = "coroutine";
		drain_stack();
		repeat (2) send_call();
		send_item(rand_pc(), enc_jalr(5'd1, 5'd5), '0);
		repeat (3) send_return();

		cur_test = "back_to_back";
		for (int i = 0; i < 80; i++) begin
			off = rand_off();
			r = rand_link();
			case (rand_bits(3))
				0: send_item(rand_pc(), enc_jal(r, off), off);
				1: send_item(rand_pc(), enc_jal(rand_nonlink(), off), off);
				2: send_return();
				3: send_item(rand_pc(), enc_jalr(r, r ^ 5'd4), '0); // x1 <-> x5 swap
				4: send_item(rand_pc(), enc_jalr(r, rand_nonlink()), '0);
				5: send_item(rand_pc(), enc_jalr(r, r), '0);
				6: send_item(rand_pc(), enc_filler(), '0);
				default: send_item(rand_pc(), enc_jalr(rand_nonlink(), rand_nonlink()), '0);
			endcase
		end

		cur_test = "drain";
		n = 0;
		while (pipe_busy() && n < 10) begin
			send_idle();
			n++;
		end
		if (pipe_busy()) begin
			$display("predictions still pending after the drain timeout");
			$display(">>> FAIL");
			$fatal(1, "drain timeout");
		end
		repeat (2) send_idle();

		if (n_checked > 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("no prediction was ever compared");
			$display(">>> FAIL");
			$fatal(1, "nothing checked");
		end
	end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// release away from the sampling edge
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK) nRST = 1'b1;
	end

endmodule

// ==== verilog.f ====
ras_pkg.sv
fetch_decode.sv
return_stack.sv
predict_out.sv
branch_predict_top.sv
tb_clock_gen.sv
tb_branch_predict.sv
